// File: common/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data path and instruction width
`define RV_XLEN 32

// register address width, 32 registers
`define RV_REG_AW 5

// pc loaded on reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: common/rv_pkg.sv
package rv_pkg;

    // major opcodes handled by the decoder
    localparam logic [6:0] OPC_R       = 7'b0110011;
    localparam logic [6:0] OPC_I_ARITH = 7'b0010011;
    localparam logic [6:0] OPC_B       = 7'b1100011;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

    localparam logic [2:0] F3_ADD_SUB  = 3'b000; // add, sub, addi, jalr
    localparam logic [2:0] F3_BNE      = 3'b001;
    localparam logic [6:0] F7_ADD      = 7'b0000000;
    localparam logic [6:0] F7_SUB      = 7'b0100000;

    localparam logic [31:0] INST_EBREAK = 32'h0010_0073; // full word match

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB} alu_op_t;

    typedef enum logic [1:0] {
        ALU_SRC_REG,     // rs1 op rs2
        ALU_SRC_IMM,     // rs1 op imm
        ALU_SRC_FOUR_PC  // pc + 4, link value
    } alu_src_t;

    typedef enum logic [1:0] {IMM_I, IMM_B, IMM_J, IMM_U} imm_op_t;

    typedef struct packed {
        logic     reg_wen;
        logic     branch;
        logic     jump;
        logic     jalr;
        logic     lui_zero_rs1;
        alu_op_t  alu_op;
        alu_src_t alu_src;
        imm_op_t  imm_op;
        logic     illegal;
        logic     ebreak;
    } ctrl_t;

endpackage

// File: common/dec_if.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

interface dec_if;

    rv_pkg::ctrl_t           ctrl;
    logic [`RV_REG_AW-1:0]   rs1;
    logic [`RV_REG_AW-1:0]   rs2;
    logic [`RV_REG_AW-1:0]   rd;
    logic [`RV_XLEN-1:0]     imm;

    modport decoder (output ctrl, output rs1, output rs2, output rd);

    modport immgen (input ctrl, output imm);

    modport rf (input rs1, input rs2);

    // execute unit sees the whole decode result
    modport exec (input ctrl, input rs1, input rs2, input rd, input imm);

endinterface

// File: decode/inst_decoder.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module inst_decoder (
    input  logic [`RV_XLEN-1:0] inst,
    dec_if.decoder              dec
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    rv_pkg::ctrl_t         c;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rd;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        // unknown encodings fall through as a non-writing no-op
        c         = '0;
        c.alu_op  = rv_pkg::ALU_ADD;
        c.alu_src = rv_pkg::ALU_SRC_REG;
        c.imm_op  = rv_pkg::IMM_I;
        c.illegal = 1'b1;
        rs1       = '0;
        rs2       = '0;
        rd        = '0;
        case (opcode)
            rv_pkg::OPC_R: begin
                if (funct3 == rv_pkg::F3_ADD_SUB &&
                    (funct7 == rv_pkg::F7_ADD || funct7 == rv_pkg::F7_SUB)) begin
                    c.illegal = 1'b0;
                    c.reg_wen = 1'b1;
                    c.alu_op  = (funct7 == rv_pkg::F7_SUB) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    rs1       = inst[19:15];
                    rs2       = inst[24:20];
                    rd        = inst[11:7];
                end
            end
            rv_pkg::OPC_I_ARITH: begin
                if (funct3 == rv_pkg::F3_ADD_SUB) begin // addi only
                    c.illegal = 1'b0;
                    c.reg_wen = 1'b1;
                    c.alu_src = rv_pkg::ALU_SRC_IMM;
                    rs1       = inst[19:15];
                    rd        = inst[11:7];
                end
            end
            rv_pkg::OPC_B: begin
                if (funct3 == rv_pkg::F3_BNE) begin
                    c.illegal = 1'b0;
                    c.branch  = 1'b1;
                    c.alu_op  = rv_pkg::ALU_SUB; // nonzero difference means taken
                    c.imm_op  = rv_pkg::IMM_B;
                    rs1       = inst[19:15];
                    rs2       = inst[24:20];
                end
            end
            rv_pkg::OPC_JAL: begin
                c.illegal = 1'b0;
                c.reg_wen = 1'b1;
                c.jump    = 1'b1;
                c.alu_src = rv_pkg::ALU_SRC_FOUR_PC; // link value
                c.imm_op  = rv_pkg::IMM_J;
                rd        = inst[11:7];
            end
            rv_pkg::OPC_JALR: begin
                if (funct3 == rv_pkg::F3_ADD_SUB) begin
                    c.illegal = 1'b0;
                    c.reg_wen = 1'b1;
                    c.jump    = 1'b1;
                    c.jalr    = 1'b1;
                    c.alu_src = rv_pkg::ALU_SRC_FOUR_PC;
                    rs1       = inst[19:15]; // target base
                    rd        = inst[11:7];
                end
            end
            rv_pkg::OPC_LUI: begin
                c.illegal      = 1'b0;
                c.reg_wen      = 1'b1;
                c.lui_zero_rs1 = 1'b1; // 0 + imm
                c.alu_src      = rv_pkg::ALU_SRC_IMM;
                c.imm_op       = rv_pkg::IMM_U;
                rd             = inst[11:7];
            end
            rv_pkg::OPC_SYSTEM: begin
                if (inst == rv_pkg::INST_EBREAK) begin
                    c.illegal = 1'b0;
                    c.ebreak  = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign dec.ctrl = c;
    assign dec.rs1  = rs1;
    assign dec.rs2  = rs2;
    assign dec.rd   = rd;

    // an illegal word must never reach the register file write port
    a_no_illegal_write: assert final (!(dec.ctrl.illegal && dec.ctrl.reg_wen));

endmodule

// File: decode/imm_gen.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module imm_gen (
    input  logic [`RV_XLEN-1:0] inst,
    dec_if.immgen               dec
);

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_u;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};

    // branch offset, bit 0 implied zero
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign imm_u = {inst[31:12], 12'b0}; // upper 20 bits, shifted by 12

    always_comb begin
        case (dec.ctrl.imm_op)
            rv_pkg::IMM_I: dec.imm = imm_i;
            rv_pkg::IMM_B: dec.imm = imm_b;
            rv_pkg::IMM_J: dec.imm = imm_j;
            rv_pkg::IMM_U: dec.imm = imm_u;
            default:       dec.imm = imm_i;
        endcase
    end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  arst_n,
    dec_if.rf                     dec,
    output logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_XLEN-1:0]   rs2_data,
    input  logic                  wen,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata
);

    logic [`RV_XLEN-1:0] regs [0:(1<<`RV_REG_AW)-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < (1 << `RV_REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin // x0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    // x0 storage never changes after reset, so it reads as zero
    assign rs1_data = regs[dec.rs1];
    assign rs2_data = regs[dec.rs2];

    a_x0_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        (dec.rs1 == '0 |-> rs1_data == '0) and (dec.rs2 == '0 |-> rs2_data == '0)
    );

endmodule

// File: source/exec_unit.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module exec_unit (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_req,
    output logic                  in_ack,
    dec_if.exec                   dec,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    output logic                  wen,
    output logic [`RV_REG_AW-1:0] waddr,
    output logic [`RV_XLEN-1:0]   wdata,
    output logic [`RV_XLEN-1:0]   pc,
    output logic                  wb_wen,
    output logic [`RV_REG_AW-1:0] wb_addr,
    output logic [`RV_XLEN-1:0]   wb_data,
    output logic                  illegal,
    output logic                  halted
);

    typedef enum logic {IDLE, ACK} state_t;

    state_t              state;
    logic                fire;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_target;
    logic [`RV_XLEN-1:0] jalr_target;
    logic                br_taken;
    logic [`RV_XLEN-1:0] next_pc;

    assign fire   = (state == IDLE) && in_req; // the one execute edge per request
    assign in_ack = (state == ACK);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else if (fire) begin
            state <= ACK;
        end else if (state == ACK && !in_req) begin
            state <= IDLE;
        end
    end

    always_comb begin
        if (dec.ctrl.lui_zero_rs1) begin
            op_a = '0;
        end else if (dec.ctrl.alu_src == rv_pkg::ALU_SRC_FOUR_PC) begin
            op_a = pc;
        end else begin
            op_a = rs1_data;
        end
        case (dec.ctrl.alu_src)
            rv_pkg::ALU_SRC_IMM:     op_b = dec.imm;
            rv_pkg::ALU_SRC_FOUR_PC: op_b = `RV_XLEN'd4;
            default:                 op_b = rs2_data;
        endcase
    end

    assign alu_res = (dec.ctrl.alu_op == rv_pkg::ALU_SUB) ? op_a - op_b : op_a + op_b;

    assign br_taken    = dec.ctrl.branch && (alu_res != '0); // bne
    assign pc_plus4    = pc + `RV_XLEN'd4;
    assign pc_target   = pc + dec.imm;
    assign jalr_target = (rs1_data + dec.imm) & ~`RV_XLEN'd1;

    always_comb begin
        if (dec.ctrl.jump && dec.ctrl.jalr) begin
            next_pc = jalr_target;
        end else if (dec.ctrl.jump || br_taken) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // register file write happens on the execute edge
    assign wen   = fire && dec.ctrl.reg_wen && !halted;
    assign waddr = dec.rd;
    assign wdata = alu_res;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= `RV_RESET_PC;
            wb_wen  <= 1'b0;
            illegal <= 1'b0;
            halted  <= 1'b0;
        end else if (fire) begin
            wb_wen  <= dec.ctrl.reg_wen && !halted;
            illegal <= dec.ctrl.illegal;
            if (!halted) begin // pc frozen after ebreak
                pc     <= next_pc;
                halted <= dec.ctrl.ebreak;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            wb_addr <= dec.rd;
            wb_data <= alu_res;
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(in_ack) |-> $past(in_req)
    );

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
    );

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_req,
    input  logic [`RV_XLEN-1:0]   in_inst,
    output logic                  in_ack,
    output logic [`RV_XLEN-1:0]   pc,
    output logic                  wb_wen,
    output logic [`RV_REG_AW-1:0] wb_addr,
    output logic [`RV_XLEN-1:0]   wb_data,
    output logic                  illegal,
    output logic                  halted
);

    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic                  rf_wen;
    logic [`RV_REG_AW-1:0] rf_waddr;
    logic [`RV_XLEN-1:0]   rf_wdata;

    dec_if i_dec_if ();

    // decoder and immediate generator both look at the raw word
    inst_decoder i_inst_decoder (
        .inst (in_inst),
        .dec  (i_dec_if.decoder)
    );

    imm_gen i_imm_gen (
        .inst (in_inst),
        .dec  (i_dec_if.immgen)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .dec      (i_dec_if.rf),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (rf_wen),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata)
    );

    exec_unit i_exec_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .dec      (i_dec_if.exec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (rf_wen),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata),
        .pc       (pc),
        .wb_wen   (wb_wen),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .illegal  (illegal),
        .halted   (halted)
    );

endmodule

// File: verif/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_core;

    localparam int N_RAND     = 30;              // random instructions per arithmetic kind
    localparam int N_INST     = 3 * N_RAND + 60;
    localparam int MAX_CYCLES = 8 * N_INST + 50;

    logic                  clk;
    logic                  arst_n;
    logic                  in_req;
    logic [`RV_XLEN-1:0]   in_inst;
    logic                  in_ack;
    logic [`RV_XLEN-1:0]   pc;
    logic                  wb_wen;
    logic [`RV_REG_AW-1:0] wb_addr;
    logic [`RV_XLEN-1:0]   wb_data;
    logic                  illegal;
    logic                  halted;

    logic [31:0] model_regs [0:31];
    logic [31:0] model_pc;
    logic        model_halted;
    logic        next_wen;       // model result for the instruction in flight
    logic [4:0]  next_addr;
    logic [31:0] next_data;
    logic        next_ill;
    logic [31:0] next_pc;
    logic        next_halt;
    logic        exp_wen;
    logic [4:0]  exp_addr;
    logic [31:0] exp_data;
    logic        exp_ill;
    logic [31:0] exp_pc;
    logic        exp_halt;
    string       test_name;
    int          value_errors;
    int          proto_errors;
    int          cycles;

    rv_core i_rv_core (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles <= MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: handshake stalled, run stopped after %0d cycles", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    always @(posedge in_ack) begin // expected values frozen for the ack phase
        exp_wen  = next_wen;
        exp_addr = next_addr;
        exp_data = next_data;
        exp_ill  = next_ill;
        exp_pc   = next_pc;
        exp_halt = next_halt;
    end

    function automatic void report_mismatch(input string what, input logic [31:0] expected,
                                            input logic [31:0] actual);
        value_errors++;
        $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
    endfunction

    function automatic void report_protocol(input string msg);
        proto_errors++;
        $display("handshake error during %s: %s", test_name, msg);
    endfunction

    a_wen: assert property (@(posedge clk) disable iff (!arst_n) in_ack |-> wb_wen == exp_wen)
        else report_mismatch("wb_wen", 32'(exp_wen), 32'(wb_wen));
    a_addr: assert property (@(posedge clk) disable iff (!arst_n)
        in_ack && exp_wen |-> wb_addr == exp_addr)
        else report_mismatch("wb_addr", 32'(exp_addr), 32'(wb_addr));
    a_data: assert property (@(posedge clk) disable iff (!arst_n)
        in_ack && exp_wen |-> wb_data == exp_data)
        else report_mismatch("wb_data", exp_data, wb_data);
    a_ill: assert property (@(posedge clk) disable iff (!arst_n) in_ack |-> illegal == exp_ill)
        else report_mismatch("illegal", 32'(exp_ill), 32'(illegal));
    a_pc: assert property (@(posedge clk) disable iff (!arst_n) in_ack |-> pc == exp_pc)
        else report_mismatch("pc", exp_pc, pc);
    a_halt: assert property (@(posedge clk) disable iff (!arst_n) in_ack |-> halted == exp_halt)
        else report_mismatch("halted", 32'(exp_halt), 32'(halted));
    a_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_req) |=> $rose(in_ack))
        else report_protocol("in_ack did not rise one cycle after in_req");
    a_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(in_req) |=> $fell(in_ack))
        else report_protocol("in_ack did not fall one cycle after in_req dropped");
    a_ack_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !in_req && !in_ack |=> !in_ack)
        else report_protocol("in_ack rose without a request");

    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(31, 0));
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, 3'b000, rd, opc};
    endfunction

    task automatic send_inst(input string name, input logic [31:0] inst, input logic wen,
                             input logic [4:0] rd, input logic [31:0] data, input logic ill,
                             input logic [31:0] target, input logic brk);
        test_name = name;
        next_wen  = wen && !model_halted; // a halted core writes nothing
        next_addr = rd;
        next_data = data;
        next_ill  = ill;
        if (!model_halted) begin
            model_pc     = target;
            model_halted = brk;
        end
        next_pc   = model_pc;
        next_halt = model_halted;
        if (next_wen && rd != 5'd0) begin
            model_regs[rd] = data;
        end
        in_inst = inst;
        in_req  = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!in_ack);
        in_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (in_ack);
    endtask

    task automatic do_add(input logic [4:0] rd, rs1, rs2, input logic sub);
        send_inst(sub ? "sub" : "add", enc_r(sub ? 7'h20 : 7'h00, rs2, rs1, rd), 1'b1, rd,
                  sub ? model_regs[rs1] - model_regs[rs2] : model_regs[rs1] + model_regs[rs2],
                  1'b0, model_pc + 32'd4, 1'b0);
    endtask

    task automatic do_addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        send_inst("addi", enc_i(imm, rs1, rd, 7'b0010011), 1'b1, rd,
                  model_regs[rs1] + {{20{imm[11]}}, imm}, 1'b0, model_pc + 32'd4, 1'b0);
    endtask

    task automatic do_lui(input logic [4:0] rd, input logic [19:0] imm);
        send_inst("lui", {imm, rd, 7'b0110111}, 1'b1, rd, {imm, 12'h000}, 1'b0,
                  model_pc + 32'd4, 1'b0);
    endtask

    task automatic do_jal(input logic [4:0] rd, input logic [20:0] off);
        send_inst("jal", {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111}, 1'b1, rd,
                  model_pc + 32'd4, 1'b0, model_pc + {{11{off[20]}}, off}, 1'b0);
    endtask

    task automatic do_jalr(input logic [4:0] rd, rs1, input logic [11:0] imm);
        send_inst("jalr", enc_i(imm, rs1, rd, 7'b1100111), 1'b1, rd, model_pc + 32'd4, 1'b0,
                  (model_regs[rs1] + {{20{imm[11]}}, imm}) & ~32'd1, 1'b0);
    endtask

    task automatic do_bne(input logic [4:0] rs1, rs2, input logic [12:0] off);
        send_inst("bne", {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011},
                  1'b0, 5'd0, 32'd0, 1'b0, (model_regs[rs1] != model_regs[rs2]) ?
                  model_pc + {{19{off[12]}}, off} : model_pc + 32'd4, 1'b0);
    endtask

    task automatic do_nowrite(input string name, input logic [31:0] inst, input logic ill,
                              input logic brk);
        send_inst(name, inst, 1'b0, 5'd0, 32'd0, ill, model_pc + 32'd4, brk);
    endtask

    initial begin
        logic [20:0] off_j;
        void'($urandom(71));
        arst_n       = 1'b0;
        in_req       = 1'b0;
        in_inst      = '0;
        value_errors = 0;
        proto_errors = 0;
        test_name    = "reset";
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc     = `RV_RESET_PC;
        model_halted = 1'b0;
        exp_wen      = 1'b0;
        exp_ill      = 1'b0;
        exp_halt     = 1'b0;
        exp_pc       = `RV_RESET_PC;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        a_reset_low: assert (!in_ack && !wb_wen && !illegal && !halted)
            else report_protocol("in_ack, wb_wen, illegal or halted high after reset");
        a_reset_pc: assert (pc == `RV_RESET_PC)
            else report_mismatch("reset pc", `RV_RESET_PC, pc);

        for (int i = 1; i < 32; i++) begin // random contents first
            do_addi(5'(i), 5'd0, 12'($urandom));
        end
        repeat (N_RAND) begin
            do_add(rand_reg(), rand_reg(), rand_reg(), 1'b0);
            do_add(rand_reg(), rand_reg(), rand_reg(), 1'b1);
            do_addi(rand_reg(), rand_reg(), 12'($urandom));
        end
        do_addi(5'd0, 5'd1, 12'h05a); // x0 must stay zero
        do_add(5'd7, 5'd0, 5'd0, 1'b0);

        do_lui(5'd10, 20'($urandom));
        repeat (2) @(posedge clk);    // idle gap with in_ack low
        #1;
        do_lui(5'd11, 20'hfffff);
        off_j = 21'(int'($urandom_range(0, 63)) * 4 - 128);
        do_jal(5'd1, off_j);
        do_jal(5'd2, 21'h000100);
        do_addi(5'd5, 5'd0, 12'h200);
        do_jalr(5'd1, 5'd5, 12'h045); // target bit 0 cleared
        do_jalr(5'd3, 5'd5, 12'hff9);

        do_addi(5'd8, 5'd0, 12'd7);
        do_addi(5'd9, 5'd0, 12'd9);
        do_bne(5'd8, 5'd9, 13'h0040);
        do_bne(5'd8, 5'd8, 13'h0040);
        do_bne(5'd0, 5'd9, 13'h1ff0);

        do_nowrite("illegal load", 32'h0000_2003, 1'b1, 1'b0);
        do_nowrite("illegal funct7", enc_r(7'h01, 5'd2, 5'd3, 5'd4), 1'b1, 1'b0);
        do_nowrite("illegal ones", 32'hffff_ffff, 1'b1, 1'b0);

        do_nowrite("ebreak", 32'h0010_0073, 1'b0, 1'b1);
        do_add(5'd12, 5'd8, 5'd9, 1'b0);   // acknowledged without a write
        do_addi(5'd13, 5'd0, 12'h123);
        do_jal(5'd1, 21'h000040);
        do_nowrite("illegal after halt", 32'h0000_2003, 1'b1, 1'b0);

        repeat (2) @(posedge clk);
        $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+common
common/rv_pkg.sv
common/dec_if.sv
decode/inst_decoder.sv
decode/imm_gen.sv
source/reg_file.sv
source/exec_unit.sv
source/rv_core.sv
verif/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
